// File: design/cachePkg.sv
`default_nettype none

package cachePkg;

  // Block geometry
  localparam int blockWords = 4;
  localparam int offsetBits = 4;

  typedef logic [31:0] dataWord;
  typedef logic [31:0] byteAddr;
  typedef logic [31-offsetBits:0] blockAddr;
  typedef logic [3:0] byteMaskVec;
  typedef logic [$clog2(blockWords)-1:0] wordOffset;

  // Request from the memory stage, held until stall is low
  typedef struct packed {
    logic       read;
    logic       write;
    byteAddr    addr;
    byteMaskVec byteMask;
    dataWord    writeData;
  } cpuRequest;

  // Word-serial memory bus, one word per busReady
  typedef struct packed {
    logic    request;
    logic    write;
    byteAddr addr;
    dataWord writeData;
  } busRequest;

  // Lookup result for the addressed set
  typedef struct packed {
    logic     hitWay0;
    logic     hitWay1;
    logic     victimWay;
    logic     victimDirty;
    blockAddr victimTagAddr;
  } wayStatus;

endpackage

`default_nettype wire

// File: design/burstCounter.sv
`default_nettype none
`timescale 1ns/1ns

module burstCounter (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  logic                step,
  output cachePkg::wordOffset addrOffset,
  output cachePkg::wordOffset dataOffset,
  output logic                lastWord
);
  import cachePkg::*;

  wordOffset count;

  // Transfer count within the current burst
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  // The bus retires each word in place, so data lines up with the address
  assign addrOffset = count;
  assign dataOffset = count;

  assign lastWord = (count == wordOffset'(blockWords - 1));

  // Controller clears instead of stepping on the final word
  stepDuringClear: assert property (@(posedge clk) disable iff (reset)
    !(step && clear));

endmodule

`default_nettype wire

// File: design/tagStore.sv
`default_nettype none
`timescale 1ns/1ns

module tagStore #(
  parameter int lines = 16,
  localparam int setBits = $clog2(lines),
  localparam int tagBits = 32 - cachePkg::offsetBits - setBits
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [setBits-1:0] setIndex,
  input  logic [tagBits-1:0] tagIn,
  input  logic               tagWrite,
  input  logic               fillWay,
  input  logic               markDirty,
  input  logic               hitWayWrite,
  input  logic               touchLru,
  output cachePkg::wayStatus status
);
  import cachePkg::*;

  logic [tagBits-1:0] tag0 [lines];
  logic [tagBits-1:0] tag1 [lines];

  logic [lines-1:0] valid0;
  logic [lines-1:0] valid1;
  logic [lines-1:0] dirty0;
  logic [lines-1:0] dirty1;
  // Set bit means way 1 is the least recently used
  logic [lines-1:0] lru;

  logic               victim;
  logic [tagBits-1:0] victimTag;

  // Tag arrays, written once per refill
  always_ff @(posedge clk) begin
    if (tagWrite && !fillWay) begin
      tag0[setIndex] <= tagIn;
    end
    if (tagWrite && fillWay) begin
      tag1[setIndex] <= tagIn;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      valid0 <= '0;
      valid1 <= '0;
      dirty0 <= '0;
      dirty1 <= '0;
      lru    <= '0;
    end else begin
      // Refilled block arrives clean
      if (tagWrite) begin
        if (fillWay) begin
          valid1[setIndex] <= 1'b1;
          dirty1[setIndex] <= 1'b0;
        end else begin
          valid0[setIndex] <= 1'b1;
          dirty0[setIndex] <= 1'b0;
        end
      end
      if (markDirty) begin
        if (hitWayWrite) begin
          dirty1[setIndex] <= 1'b1;
        end else begin
          dirty0[setIndex] <= 1'b1;
        end
      end
      // Point away from the way just used
      if (touchLru) begin
        lru[setIndex] <= ~hitWayWrite;
      end
    end
  end

  always_comb begin
    status.hitWay0 = valid0[setIndex] && (tag0[setIndex] == tagIn);
    status.hitWay1 = valid1[setIndex] && (tag1[setIndex] == tagIn);

    // Empty way first, otherwise LRU
    if (!valid0[setIndex]) begin
      victim = 1'b0;
    end else if (!valid1[setIndex]) begin
      victim = 1'b1;
    end else begin
      victim = lru[setIndex];
    end

    victimTag = victim ? tag1[setIndex] : tag0[setIndex];
    status.victimWay = victim;
    status.victimDirty = victim ? dirty1[setIndex] : dirty0[setIndex];
    status.victimTagAddr = blockAddr'({victimTag, setIndex});
  end

  // Refill only happens after a miss in both ways
  bothWaysHit: assert property (@(posedge clk) disable iff (reset)
    !(status.hitWay0 && status.hitWay1));

endmodule

`default_nettype wire

// File: design/dataStore.sv
`default_nettype none
`timescale 1ns/1ns

module dataStore #(
  parameter int lines = 16,
  localparam int setBits = $clog2(lines)
) (
  input  logic                 clk,
  input  logic [setBits-1:0]   setIndex,
  input  logic                 way,
  input  cachePkg::wordOffset  offset,
  input  logic                 writeEnable,
  input  cachePkg::byteMaskVec byteMask,
  input  cachePkg::dataWord    writeData,
  output cachePkg::dataWord    readData
);
  import cachePkg::*;

  dataWord way0Mem [lines][blockWords];
  dataWord way1Mem [lines][blockWords];

  dataWord mergedWord;

  // Asynchronous read, shared by CPU loads and write-back
  assign readData = way ? way1Mem[setIndex][offset] : way0Mem[setIndex][offset];

  // Masked bytes replace the stored ones
  always_comb begin
    for (int b = 0; b < $bits(byteMaskVec); b++) begin
      if (byteMask[b]) begin
        mergedWord[8*b +: 8] = writeData[8*b +: 8];
      end else begin
        mergedWord[8*b +: 8] = readData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      if (way) begin
        way1Mem[setIndex][offset] <= mergedWord;
      end else begin
        way0Mem[setIndex][offset] <= mergedWord;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/cacheController.sv
`default_nettype none
`timescale 1ns/1ns

module cacheController (
  input  logic                clk,
  input  logic                reset,
  input  cachePkg::cpuRequest cpu,
  input  cachePkg::wayStatus  status,
  input  logic                busReady,
  input  logic                lastWord,
  output logic                stall,
  output logic                request,
  output logic                write,
  output logic                fillWay,
  output logic                tagWrite,
  output logic                dataWrite,
  output logic                markDirty,
  output logic                touchLru,
  output logic                counterClear,
  output logic                counterStep,
  output logic                useCounter,
  output logic                selectWay
);

  typedef enum logic [1:0] {
    ready,
    writeBack,
    fill,
    complete
  } ctrlState;

  ctrlState state;
  ctrlState nextState;

  logic access;
  logic hit;
  logic burstDone;

  assign access = cpu.read | cpu.write;
  assign hit = status.hitWay0 | status.hitWay1;
  // Fourth word retired this cycle
  assign burstDone = busReady & lastWord;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  // Victim way is held for the whole miss
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fillWay <= 1'b0;
    end else if (state == ready && access && !hit) begin
      fillWay <= status.victimWay;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (access && !hit) begin
          nextState = status.victimDirty ? writeBack : fill;
        end
      end
      writeBack: begin
        if (burstDone) begin
          nextState = fill;
        end
      end
      fill: begin
        if (burstDone) begin
          nextState = complete;
        end
      end
      complete: nextState = ready;
      default: nextState = ready;
    endcase
  end

  always_comb begin
    stall        = 1'b0;
    request      = 1'b0;
    write        = 1'b0;
    tagWrite     = 1'b0;
    dataWrite    = 1'b0;
    markDirty    = 1'b0;
    touchLru     = 1'b0;
    counterClear = 1'b0;
    counterStep  = 1'b0;
    useCounter   = 1'b0;
    selectWay    = fillWay;
    case (state)
      ready: begin
        // Hits finish here with no stall
        stall        = access & ~hit;
        touchLru     = access & hit;
        dataWrite    = cpu.write & hit;
        markDirty    = cpu.write & hit;
        counterClear = 1'b1;
        selectWay    = status.hitWay1;
      end
      writeBack: begin
        stall        = 1'b1;
        request      = 1'b1;
        write        = 1'b1;
        useCounter   = 1'b1;
        counterStep  = busReady & ~lastWord;
        counterClear = burstDone;
      end
      fill: begin
        stall        = 1'b1;
        request      = 1'b1;
        useCounter   = 1'b1;
        // Each arriving word goes straight into the array
        dataWrite    = busReady;
        counterStep  = busReady & ~lastWord;
        counterClear = burstDone;
      end
      complete: begin
        stall        = 1'b1;
        tagWrite     = 1'b1;
        counterClear = 1'b1;
      end
      default: begin
        stall = 1'b1;
      end
    endcase
  end

  // A write-back burst stays on the bus until its last word retires
  writeBackHeld: assert property (@(posedge clk) disable iff (reset)
    write && !burstDone |=> write && request);

endmodule

`default_nettype wire

// File: design/dataCache.sv
`default_nettype none
`timescale 1ns/1ns

module dataCache #(
  parameter int lines = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  cachePkg::cpuRequest cpu,
  output cachePkg::dataWord   readData,
  output logic                stall,
  output cachePkg::busRequest bus,
  input  cachePkg::dataWord   busReadData,
  input  logic                busReady
);
  import cachePkg::*;

  localparam int setBits = $clog2(lines);
  localparam int tagBits = 32 - offsetBits - setBits;

  logic [tagBits-1:0] tagField;
  logic [setBits-1:0] setIndex;
  wordOffset          cpuWord;

  wayStatus status;
  logic     fillWay;
  logic     tagWrite;
  logic     dataWrite;
  logic     markDirty;
  logic     touchLru;
  logic     counterClear;
  logic     counterStep;
  logic     useCounter;
  logic     selectWay;
  logic     busActive;
  logic     busWrite;

  wordOffset  addrOffset;
  wordOffset  dataOffset;
  logic       lastWord;
  wordOffset  storeOffset;
  byteMaskVec storeMask;
  dataWord    storeData;
  dataWord    storeRead;
  blockAddr   busBlock;

  // Address fields
  assign tagField = cpu.addr[31 -: tagBits];
  assign setIndex = cpu.addr[offsetBits +: setBits];
  assign cpuWord  = cpu.addr[offsetBits-1 -: $bits(wordOffset)];

  // Bursts index the array from the counter and take full bus words
  assign storeOffset = useCounter ? dataOffset : cpuWord;
  assign storeMask   = useCounter ? '1 : cpu.byteMask;
  assign storeData   = useCounter ? busReadData : cpu.writeData;

  // Write-back targets the victim block, refill the requested one
  assign busBlock = busWrite ? status.victimTagAddr : cpu.addr[31:offsetBits];

  assign bus.request   = busActive;
  assign bus.write     = busWrite;
  assign bus.addr      = {busBlock, addrOffset, 2'b00};
  assign bus.writeData = storeRead;

  assign readData = storeRead;

  cacheController ctrl0 (
    .clk          (clk),
    .reset        (reset),
    .cpu          (cpu),
    .status       (status),
    .busReady     (busReady),
    .lastWord     (lastWord),
    .stall        (stall),
    .request      (busActive),
    .write        (busWrite),
    .fillWay      (fillWay),
    .tagWrite     (tagWrite),
    .dataWrite    (dataWrite),
    .markDirty    (markDirty),
    .touchLru     (touchLru),
    .counterClear (counterClear),
    .counterStep  (counterStep),
    .useCounter   (useCounter),
    .selectWay    (selectWay)
  );

  burstCounter counter0 (
    .clk        (clk),
    .reset      (reset),
    .clear      (counterClear),
    .step       (counterStep),
    .addrOffset (addrOffset),
    .dataOffset (dataOffset),
    .lastWord   (lastWord)
  );

  tagStore #(.lines(lines)) tags0 (
    .clk         (clk),
    .reset       (reset),
    .setIndex    (setIndex),
    .tagIn       (tagField),
    .tagWrite    (tagWrite),
    .fillWay     (fillWay),
    .markDirty   (markDirty),
    .hitWayWrite (selectWay),
    .touchLru    (touchLru),
    .status      (status)
  );

  dataStore #(.lines(lines)) data0 (
    .clk         (clk),
    .setIndex    (setIndex),
    .way         (selectWay),
    .offset      (storeOffset),
    .writeEnable (dataWrite),
    .byteMask    (storeMask),
    .writeData   (storeData),
    .readData    (storeRead)
  );

endmodule

`default_nettype wire

// File: verification/cacheChecker.sv
`default_nettype none
`timescale 1ns/1ns

module cacheChecker (
  input  logic                clk,
  input  logic                reset,
  input  cachePkg::cpuRequest cpu,
  input  cachePkg::dataWord   readData,
  input  logic                stall,
  input  cachePkg::busRequest bus,
  input  logic                busReady,
  output int                  errorCount
);
  import cachePkg::*;

  localparam int memWords = 1024;

  // Expected memory contents as the CPU sees them
  dataWord shadow [memWords];
  int      errors = 0;

  assign errorCount = errors;

  // Reference rule for a masked store
  function automatic dataWord mergeBytes(input dataWord oldWord, input dataWord newData,
                                         input byteMaskVec mask);
    dataWord merged;
    merged = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = newData[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Same fill pattern the memory model starts from
  initial begin
    for (int i = 0; i < memWords; i++) begin
      shadow[i] = (i * 32'h9e3779b9) ^ 32'h5a5a0000;
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (cpu.write && !stall) begin
        shadow[cpu.addr[11:2]] <= mergeBytes(shadow[cpu.addr[11:2]], cpu.writeData,
                                             cpu.byteMask);
      end
      if (cpu.read && !stall && readData !== shadow[cpu.addr[11:2]]) begin
        $display("ERROR at %0t ns: readData at %h expected %h actual %h", $time, cpu.addr,
                 shadow[cpu.addr[11:2]], readData);
        errors = errors + 1;
      end
      // Write-back must carry the latest CPU data
      if (bus.request && bus.write && busReady &&
          bus.writeData !== shadow[bus.addr[11:2]]) begin
        $display("ERROR at %0t ns: bus.writeData at %h expected %h actual %h", $time,
                 bus.addr, shadow[bus.addr[11:2]], bus.writeData);
        errors = errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/cacheTb.sv
`default_nettype none
`timescale 1ns/1ns

module cacheTb;
  import cachePkg::*;

  localparam int timeoutCycles = 200;
  localparam int memWords = 1024;

  logic      clk = 1'b0;
  logic      reset;
  cpuRequest cpu;
  dataWord   readData;
  logic      stall;
  busRequest bus;
  dataWord   busReadData;
  logic      busReady = 1'b0;

  dataWord     memory [memWords];
  int          busWords = 0;
  int          stallTotal = 0;
  logic [7:0]  writeHistory = '0;
  logic [31:0] gapState = 32'h3727;
  logic [31:0] stimState = 32'h3727;
  int          checkerErrors;
  int          localErrors = 0;
  int          testsRun = 0;
  int          testsPassed = 0;
  int          testStart = 0;

  always #2 clk = ~clk;

  dataCache #(.lines(16)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .cpu         (cpu),
    .readData    (readData),
    .stall       (stall),
    .bus         (bus),
    .busReadData (busReadData),
    .busReady    (busReady)
  );

  cacheChecker check0 (
    .clk        (clk),
    .reset      (reset),
    .cpu        (cpu),
    .readData   (readData),
    .stall      (stall),
    .bus        (bus),
    .busReady   (busReady),
    .errorCount (checkerErrors)
  );

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  assign busReadData = memory[bus.addr[11:2]];

  // Memory side of the bus, ready pulses with random gaps
  always @(posedge clk) begin
    if (!reset && bus.request && busReady) begin
      if (bus.write) begin
        memory[bus.addr[11:2]] <= bus.writeData;
      end
      busWords <= busWords + 1;
      writeHistory <= {writeHistory[6:0], bus.write};
    end
    gapState <= lcg(gapState);
    busReady <= (gapState[17:16] != 2'b00);
  end

  // Presents one request and returns at the edge that accepts it
  task automatic access(input logic isWrite, input byteAddr addr, input byteMaskVec mask,
                        input dataWord data);
    int waited;
    cpu <= '{read: ~isWrite, write: isWrite, addr: addr, byteMask: mask, writeData: data};
    waited = 0;
    @(negedge clk);
    while (stall && waited < timeoutCycles) begin
      @(negedge clk);
      waited++;
    end
    if (stall) begin
      $display("Timeout: stall stayed high for %0d cycles at address %h", waited, addr);
      $display("*** FAILED ***");
      $finish;
    end else begin
      stallTotal += waited;
      @(posedge clk);
    end
  endtask

  task automatic readWord(input byteAddr addr);
    access(1'b0, addr, 4'hf, '0);
  endtask

  task automatic writeWord(input byteAddr addr, input byteMaskVec mask, input dataWord data);
    access(1'b1, addr, mask, data);
  endtask

  task automatic expectBusWords(input int since, input int expected, input string what);
    if (busWords - since != expected) begin
      $display("ERROR at %0t ns: bus word count during %s expected %0d actual %0d", $time,
               what, expected, busWords - since);
      localErrors++;
    end
  endtask

  // Hits are accepted at the edge that ends the presenting cycle
  task automatic expectNoStall(input int since, input string what);
    if (stallTotal - since != 0) begin
      $display("ERROR at %0t ns: stall cycles during %s expected 0 actual %0d", $time,
               what, stallTotal - since);
      localErrors++;
    end
  endtask

  // Idles the CPU and reports the test once the checker has settled
  task automatic endTest(input string name);
    int errorsNow;
    cpu <= '0;
    @(negedge clk);
    errorsNow = localErrors + checkerErrors;
    testsRun++;
    if (errorsNow == testStart) begin
      testsPassed++;
      $display("Test %0d %s: ok", testsRun, name);
    end else begin
      $display("Test %0d %s: %0d errors", testsRun, name, errorsNow - testStart);
    end
    testStart = errorsNow;
    @(posedge clk);
  endtask

  initial begin
    int      since;
    int      stallSince;
    byteAddr addr;
    reset = 1'b1;
    cpu = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < memWords; i++) begin
      memory[i] = check0.shadow[i];
    end
    @(posedge clk);

    since = busWords;
    readWord(32'h040);
    expectBusWords(since, 4, "read miss");
    if (writeHistory[3:0] != 4'b0000) begin
      $display("ERROR at %0t ns: bus.write history expected 0000 actual %b", $time,
               writeHistory[3:0]);
      localErrors++;
    end
    endTest("read miss");

    since = busWords;
    stallSince = stallTotal;
    readWord(32'h04c);
    readWord(32'h040);
    readWord(32'h044);
    expectBusWords(since, 0, "repeat reads");
    expectNoStall(stallSince, "repeat reads");
    endTest("read hit");

    since = busWords;
    stallSince = stallTotal;
    writeWord(32'h048, 4'b0101, 32'hdeadbeef);
    readWord(32'h048);
    expectBusWords(since, 0, "masked write hit");
    expectNoStall(stallSince, "masked write hit");
    endTest("masked write hit");

    // Blocks A, B and C all map to set 3
    since = busWords;
    readWord(32'h030);
    readWord(32'h130);
    expectBusWords(since, 8, "two fills");
    since = busWords;
    stallSince = stallTotal;
    readWord(32'h034);
    readWord(32'h138);
    writeWord(32'h130, 4'hf, 32'h12345678);
    readWord(32'h030);
    expectBusWords(since, 0, "resident blocks");
    expectNoStall(stallSince, "resident blocks");
    since = busWords;
    readWord(32'h230);
    expectBusWords(since, 8, "dirty eviction");
    if (writeHistory != 8'b11110000) begin
      $display("ERROR at %0t ns: bus.write history expected 11110000 actual %b", $time,
               writeHistory);
      localErrors++;
    end
    since = busWords;
    stallSince = stallTotal;
    readWord(32'h03c);
    expectBusWords(since, 0, "survivor read");
    expectNoStall(stallSince, "survivor read");
    endTest("LRU eviction");

    for (int n = 0; n < 300; n++) begin
      stimState = lcg(stimState);
      addr = {22'b0, stimState[25:18], 2'b00};
      if (stimState[30]) begin
        writeWord(addr, stimState[3:0], lcg(stimState));
      end else begin
        readWord(addr);
      end
    end
    // Two conflicting blocks per set push every dirty line out
    for (int s = 0; s < 16; s++) begin
      readWord(32'h800 + s * 16);
      readWord(32'hc00 + s * 16);
    end
    for (int i = 0; i < memWords; i++) begin
      if (memory[i] !== check0.shadow[i]) begin
        $display("ERROR at %0t ns: memory[%0d] expected %h actual %h", $time, i,
                 check0.shadow[i], memory[i]);
        localErrors++;
      end
    end
    endTest("random traffic");

    $display("Tests passed %0d of %0d, errors %0d", testsPassed, testsRun,
             localErrors + checkerErrors);
    if (testsPassed == testsRun && localErrors + checkerErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/cachePkg.sv
design/burstCounter.sv
design/tagStore.sv
design/dataStore.sv
design/cacheController.sv
design/dataCache.sv
verification/cacheChecker.sv
verification/cacheTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cacheTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi
